//--- list.f
+incdir+hdl
hdl/uart_cmd_pkg.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_seq.sv
hdl/uart_cmd_top.sv
testbench/uart_cmd_chk.sv
testbench/tb_uart_cmd.sv

//--- Bender.yml
package:
  name: uart_cmd

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_cmd_pkg.sv
      - hdl/uart_tx_frame.sv
      - hdl/uart_rx_frame.sv
      - hdl/uart_cmd_seq.sv
      - hdl/uart_cmd_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/uart_cmd_chk.sv
      - testbench/tb_uart_cmd.sv

//--- testbench/tb_uart_cmd.sv
`include "uart_cmd_consts.svh"

module tb_uart_cmd;

  import uart_cmd_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int frame_cycles = `UART_FRAME_BITS * clks_per_bit;
  localparam int frame_wait = 4 * frame_cycles;
  localparam int num_tests = 6;
  localparam longint watchdog_time = num_tests *
    (2 + `UART_GAP_BITS + `UART_RESP_TIMEOUT_BITS) * `UART_FRAME_BITS * clks_per_bit * 20 * 2;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       tx;
  logic       rx;
  logic       read_rdy;
  read_resp_t read_resp;

  integer     seed;
  int         cyc = 0;
  int         rdy_cnt = 0;
  int         rdy_cyc = 0;
  read_resp_t resp_q;
  int         errors = 0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;

  uart_cmd_top #(.clks_per_bit(clks_per_bit)) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  bind uart_cmd_top uart_cmd_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // read_rdy is a single-cycle pulse, so it is caught here and not by the tests.
  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
    begin
      rdy_cnt = rdy_cnt + 1;
      rdy_cyc = cyc;
      resp_q  = read_resp;
    end
  end

  initial
  begin
    #(watchdog_time);
    $display("Error: watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_resp(input string name, input read_resp_t exp, input read_resp_t got);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start)
    begin
      pass_cnt++;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < limit)
    begin
      step(1);
      n++;
    end
    if (cmd_rdy !== 1'b1)
    begin
      errors++;
      $display("Error: cmd_rdy did not return high within %0d cycles", limit);
    end
  endtask

  task automatic wait_read_rdy(input int prev, input int limit, output bit got);
    int n;
    n = 0;
    while (rdy_cnt == prev && n < limit)
    begin
      step(1);
      n++;
    end
    got = (rdy_cnt != prev);
    if (!got)
    begin
      errors++;
      $display("Error: read_rdy did not pulse within %0d cycles", limit);
    end
  endtask

  task automatic send_cmd(input cmd_t c);
    wait_cmd_rdy(frame_wait);
    cmd     = c;
    cmd_vld = 1'b1;
    step(1);
    cmd_vld = 1'b0;
    check_bit("cmd_rdy", 1'b0, cmd_rdy);
  endtask

  // samples tx in the middle of each bit, one negedge at a time.
  task automatic expect_frame(input logic [7:0] exp, output int start_cyc);
    logic [7:0] data;
    logic       par;
    logic       stop;
    int         waited;
    int         i;
    waited    = 0;
    start_cyc = 0;
    @(negedge clk);
    while (tx !== 1'b0 && waited < frame_wait)
    begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0)
    begin
      errors++;
      $display("Error: no start bit on tx within %0d cycles", frame_wait);
    end
    else
    begin
      start_cyc = cyc;
      repeat (clks_per_bit / 2) @(negedge clk);
      check_bit("tx start bit", 1'b0, tx);
      for (i = 0; i < 8; i++)
      begin
        repeat (clks_per_bit) @(negedge clk);
        data[i] = tx;
      end
      repeat (clks_per_bit) @(negedge clk);
      par = tx;
      repeat (clks_per_bit) @(negedge clk);
      stop = tx;
      check_byte("tx data", exp, data);
      check_bit("tx parity", ^exp, par); // even parity over the data byte.
      check_bit("tx stop bit", 1'b1, stop);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic drive_frame(input logic [7:0] b, input bit bad_parity);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (^b) ^ bad_parity, b, 1'b0};
    for (i = 0; i < `UART_FRAME_BITS; i++)
    begin
      rx = bits[i];
      step(clks_per_bit);
    end
  endtask

  task automatic test_reset();
    int err_start;
    err_start = errors;
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_bit("tx", 1'b1, tx);
    check_bit("read_rdy", 1'b0, read_rdy);
    finish_test("reset", err_start);
  endtask

  task automatic test_write();
    cmd_t c;
    int   s1;
    int   s2;
    int   gap;
    int   err_start;
    err_start = errors;
    c = '{write: 1'b1, addr: 7'(rand_byte()), data: rand_byte()};
    send_cmd(c);
    expect_frame({c.write, c.addr}, s1);
    expect_frame(c.data, s2);
    gap = s2 - s1 - frame_cycles;
    if (gap < `UART_GAP_BITS * clks_per_bit || gap > `UART_GAP_BITS * clks_per_bit + 2)
    begin
      errors++;
      $display("Error: gap between write frames was %0d cycles, expected %0d to %0d", gap,
               `UART_GAP_BITS * clks_per_bit, `UART_GAP_BITS * clks_per_bit + 2);
    end
    wait_cmd_rdy(2 * clks_per_bit);
    finish_test("write", err_start);
  endtask

  task automatic test_read(input string name, input bit bad_parity);
    cmd_t       c;
    logic [7:0] resp_byte;
    read_resp_t exp;
    int         start;
    int         prev;
    bit         got;
    int         err_start;
    err_start = errors;
    c = '{write: 1'b0, addr: 7'(rand_byte()), data: rand_byte()};
    resp_byte = rand_byte();
    prev = rdy_cnt;
    send_cmd(c);
    expect_frame({c.write, c.addr}, start);
    step(2 * clks_per_bit); // the receiver is armed only after the request stop bit.
    drive_frame(resp_byte, bad_parity);
    wait_read_rdy(prev, 4 * clks_per_bit, got);
    if (got)
    begin
      exp = '{data: resp_byte, parity_err: bad_parity, frame_err: 1'b0, timeout: 1'b0};
      check_resp("read_resp", exp, resp_q);
    end
    finish_test(name, err_start);
  endtask

  task automatic test_timeout();
    cmd_t       c;
    read_resp_t exp;
    int         start;
    int         prev;
    int         latency;
    bit         got;
    int         err_start;
    err_start = errors;
    c = '{write: 1'b0, addr: 7'(rand_byte()), data: rand_byte()};
    prev = rdy_cnt;
    send_cmd(c);
    expect_frame({c.write, c.addr}, start);
    wait_read_rdy(prev, (`UART_RESP_TIMEOUT_BITS + 3) * clks_per_bit, got);
    if (got)
    begin
      latency = rdy_cyc - (start + frame_cycles);
      if (latency > (`UART_RESP_TIMEOUT_BITS + 2) * clks_per_bit)
      begin
        errors++;
        $display("Error: timeout read_rdy came %0d cycles after the request stop bit", latency);
      end
      exp = '{data: 8'h00, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
      check_resp("read_resp", exp, resp_q);
    end
    finish_test("read timeout", err_start);
  endtask

  task automatic test_busy_ignored();
    cmd_t c1;
    cmd_t c2;
    int   s1;
    int   s2;
    bit   extra;
    int   err_start;
    err_start = errors;
    c1 = '{write: 1'b1, addr: 7'(rand_byte()), data: rand_byte()};
    c2 = '{write: 1'b1, addr: ~c1.addr, data: ~c1.data};
    send_cmd(c1);
    expect_frame({c1.write, c1.addr}, s1);
    cmd     = c2; // offered during the gap while cmd_rdy is low.
    cmd_vld = 1'b1;
    step(4);
    cmd_vld = 1'b0;
    expect_frame(c1.data, s2);
    wait_cmd_rdy(2 * clks_per_bit);
    extra = 1'b0;
    repeat (3 * clks_per_bit)
    begin
      if (tx !== 1'b1)
      begin
        extra = 1'b1;
      end
      step(1);
    end
    if (extra)
    begin
      errors++;
      $display("Error: a third frame appeared on tx after the ignored command");
    end
    finish_test("busy command ignored", err_start);
  endtask

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    seed    = 32'h340f;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step(2);
    test_reset();
    test_write();
    test_read("read", 1'b0);
    test_read("read bad parity", 1'b1);
    test_timeout();
    test_busy_ignored();
    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d", pass_cnt,
             fail_cnt, i_dut.i_chk.assert_errors);
    if (errors == 0 && fail_cnt == 0 && i_dut.i_chk.assert_errors == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/uart_cmd_chk.sv
module uart_cmd_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     cmd_vld,
  input logic                     cmd_rdy,
  input logic                     tx,
  input logic                     read_rdy,
  input uart_cmd_pkg::read_resp_t read_resp
);

  int assert_errors = 0;

  // an idle bridge keeps the line in its mark state.
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else
    begin
      assert_errors++;
      $error("tx is low while cmd_rdy is high");
    end

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else
    begin
      assert_errors++;
      $error("read_rdy stayed high for two cycles");
    end

  cmd_rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
                                  (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else
    begin
      assert_errors++;
      $error("cmd_rdy did not fall after an accepted command");
    end

  timeout_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
                                      (read_rdy && read_resp.timeout) |-> (read_resp.data == 8'h00))
    else
    begin
      assert_errors++;
      $error("read_resp.data is not zero on a timeout");
    end

endmodule

//--- hdl/uart_cmd_top.sv
`include "uart_cmd_consts.svh"

module uart_cmd_top #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx,
  input  logic                     rx,
  output logic                     read_rdy,
  output uart_cmd_pkg::read_resp_t read_resp
);

  logic                    tx_start;
  logic [7:0]              tx_byte;
  logic                    tx_done;
  logic                    rx_en;
  logic                    rx_busy;
  logic                    rx_valid;
  uart_cmd_pkg::rx_frame_t rx_frame;

  uart_cmd_seq #(.clks_per_bit(clks_per_bit)) i_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_en     (rx_en),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  uart_tx_frame #(.clks_per_bit(clks_per_bit)) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame #(.clks_per_bit(clks_per_bit)) i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_en    (rx_en),
    .rx_busy  (rx_busy),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

endmodule

//--- hdl/uart_cmd_seq.sv
`include "uart_cmd_consts.svh"

module uart_cmd_seq #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  input  logic                     tx_done,
  output logic                     rx_en,
  input  logic                     rx_busy,
  input  logic                     rx_valid,
  input  uart_cmd_pkg::rx_frame_t  rx_frame,
  output logic                     read_rdy,
  output uart_cmd_pkg::read_resp_t read_resp
);

  import uart_cmd_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int max_bits = (`UART_GAP_BITS > `UART_RESP_TIMEOUT_BITS) ?
                            `UART_GAP_BITS : `UART_RESP_TIMEOUT_BITS;
  localparam int bit_w = $clog2(max_bits + 1);

  typedef enum logic [2:0] {
    s_idle,
    s_send_first,
    s_gap,
    s_send_second,
    s_wait_resp
  } state_t;

  state_t           state;
  cmd_t             cmd_q;
  logic [cnt_w-1:0] cyc_cnt;
  logic [bit_w-1:0] bit_cnt;
  logic             accept;
  logic             bit_end;
  logic             count_en;
  logic             gap_done;
  logic             timeout_hit;
  logic             resp_load;

  assign cmd_rdy = (state == s_idle);
  assign accept = cmd_vld && cmd_rdy;
  assign rx_en = (state == s_wait_resp);

  // the second frame carries the data byte, everything else sends {write, addr}.
  assign tx_byte = (state == s_send_second) ? cmd_q.data : {cmd_q.write, cmd_q.addr};

  // the timeout holds while a response frame is being received.
  assign count_en = (state == s_gap) || ((state == s_wait_resp) && !rx_busy);
  assign bit_end = (cyc_cnt == cnt_w'(clks_per_bit - 1));
  assign gap_done = (state == s_gap) && bit_end && (bit_cnt == bit_w'(`UART_GAP_BITS - 1));
  assign timeout_hit = count_en && (state == s_wait_resp) && bit_end &&
                       (bit_cnt == bit_w'(`UART_RESP_TIMEOUT_BITS - 1));
  assign resp_load = (state == s_wait_resp) && (rx_valid || timeout_hit);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= s_idle;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        s_idle:
        begin
          if (accept)
          begin
            state    <= s_send_first;
            tx_start <= 1'b1;
          end
        end
        s_send_first:
        begin
          if (tx_done)
          begin
            state <= cmd_q.write ? s_gap : s_wait_resp;
          end
        end
        s_gap:
        begin
          if (gap_done)
          begin
            state    <= s_send_second;
            tx_start <= 1'b1;
          end
        end
        s_send_second:
        begin
          if (tx_done)
          begin
            state <= s_idle;
          end
        end
        s_wait_resp:
        begin
          if (resp_load)
          begin
            state    <= s_idle;
            read_rdy <= 1'b1;
          end
        end
        default:
        begin
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (state == s_send_first)
    begin
      cyc_cnt <= '0; // both the gap and the timeout start from the first tx_done.
      bit_cnt <= '0;
    end
    else if (count_en)
    begin
      if (bit_end)
      begin
        cyc_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd;
    end
    if (resp_load)
    begin
      if (rx_valid)
      begin
        read_resp <= '{data: rx_frame.data, parity_err: rx_frame.parity_err,
                       frame_err: rx_frame.frame_err, timeout: 1'b0};
      end
      else
      begin
        read_resp <= '{data: 8'h00, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
      end
    end
  end

endmodule

//--- hdl/uart_rx_frame.sv
`include "uart_cmd_consts.svh"

module uart_rx_frame #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    rx_en,
  output logic                    rx_busy,
  output logic                    rx_valid,
  output uart_cmd_pkg::rx_frame_t rx_frame
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int half_last = clks_per_bit / 2 - 1;
  localparam int full_last = clks_per_bit - 1;
  localparam int parity_idx = `UART_DATA_BITS;
  localparam int stop_idx = `UART_DATA_BITS + 1;

  logic             rx_s1;
  logic             rx_s2;
  logic             rx_d;
  logic             start_phase;
  logic [cnt_w-1:0] cnt;
  logic [3:0]       idx;
  logic             sample;
  logic [7:0]       data_q;
  logic             parity_q;

  // the start bit is checked half a bit in, everything after it a full bit apart.
  assign sample = rx_busy && (cnt == (start_phase ? cnt_w'(half_last) : cnt_w'(full_last)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy     <= 1'b0;
      rx_valid    <= 1'b0;
      start_phase <= 1'b0;
      cnt         <= '0;
      idx         <= '0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (!rx_busy)
      begin
        if (rx_en && rx_d && !rx_s2)
        begin
          rx_busy     <= 1'b1;
          start_phase <= 1'b1;
          cnt         <= '0;
        end
      end
      else if (sample)
      begin
        cnt <= '0;
        if (start_phase)
        begin
          start_phase <= 1'b0;
          idx         <= '0;
          rx_busy     <= !rx_s2; // a glitch, not a start bit, so rearm.
        end
        else if (idx == 4'(stop_idx))
        begin
          rx_busy  <= 1'b0;
          rx_valid <= 1'b1;
        end
        else
        begin
          idx <= idx + 4'd1;
        end
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && !start_phase)
    begin
      if (idx < 4'(parity_idx))
      begin
        data_q <= {rx_s2, data_q[7:1]}; // LSB arrives first.
      end
      else if (idx == 4'(parity_idx))
      begin
        parity_q <= rx_s2;
      end
      else
      begin
        rx_frame <= '{data: data_q, parity_err: ^{data_q, parity_q}, frame_err: !rx_s2};
      end
    end
  end

endmodule

//--- hdl/uart_tx_frame.sv
`include "uart_cmd_consts.svh"

module uart_tx_frame #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int last_idx = `UART_FRAME_BITS - 1;

  logic                        busy;
  logic [cnt_w-1:0]            cnt;
  logic [3:0]                  idx;
  logic [`UART_FRAME_BITS-1:0] frame_q;
  logic                        bit_end;

  assign bit_end = busy && (cnt == cnt_w'(clks_per_bit - 1));

  // bit 0 of the frame register is the line itself.
  assign tx = frame_q[0];

  assign tx_done = bit_end && (idx == 4'(last_idx)); // last cycle of the stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      cnt     <= '0;
      idx     <= '0;
      frame_q <= '1;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy    <= 1'b1;
        cnt     <= '0;
        idx     <= '0;
        frame_q <= {1'b1, ^tx_byte, tx_byte, 1'b0}; // stop, even parity, data, start.
      end
    end
    else if (bit_end)
    begin
      cnt     <= '0;
      frame_q <= {1'b1, frame_q[`UART_FRAME_BITS-1:1]}; // ones fill in so the line idles high.
      if (idx == 4'(last_idx))
      begin
        busy <= 1'b0;
      end
      else
      begin
        idx <= idx + 4'd1;
      end
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hdl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // host command, the high byte is {write, addr}.
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // one received frame with its error flags.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } rx_frame_t;

  // result of a read as seen by the host.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
    logic       timeout;
  } read_resp_t;

endpackage

//--- hdl/uart_cmd_consts.svh
`ifndef UART_CMD_CONSTS_SVH
`define UART_CMD_CONSTS_SVH

// clock cycles per UART bit, 50 MHz at 115200 baud.
`define UART_CLKS_PER_BIT 434

// idle bit periods between the high and low byte of a write.
`define UART_GAP_BITS 4

// bit periods to wait for the start bit of a read response.
`define UART_RESP_TIMEOUT_BITS 32

// data bits in one frame, sent LSB first.
`define UART_DATA_BITS 8

// start, data, parity and stop.
`define UART_FRAME_BITS 11

`endif
